// ==== Bender.yml ====
package:
  name: lsu

sources:
  - hdl/lsu_cfg_pkg.sv
  - hdl/lsu_op_pkg.sv
  - hdl/lsu_load_align.sv
  - hdl/dmem_arbiter.sv
  - hdl/dmem.sv
  - hdl/lsu_pipe.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - tests/tb_lsu.sv

// ==== hdl/dmem.sv ====
module dmem
  import lsu_cfg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_en,
  input  logic       i_we,
  input  dmem_idx_t  i_idx,
  input  byte_mask_t i_mask,
  input  xdata_t     i_wdata,
  output xdata_t     o_rdata
);

  xdata_t r_mem [DMEM_WORDS];
  xdata_t r_rdata;

  always_ff @(posedge i_clk) begin
    if (i_en && i_we) begin
      for (int b = 0; b < BYTE_LANES; b++) begin
        if (i_mask[b]) begin
          r_mem[i_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end else if (i_en) begin
      r_rdata <= r_mem[i_idx];  // Seen by the pipes in EX2
    end
  end

  assign o_rdata = r_rdata;

endmodule

// ==== hdl/dmem_arbiter.sv ====
module dmem_arbiter
  import lsu_cfg_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_reset_n,
  input  logic       i_req0,
  input  logic       i_we0,
  input  dmem_idx_t  i_idx0,
  input  byte_mask_t i_mask0,
  input  xdata_t     i_wdata0,
  input  logic       i_req1,
  input  logic       i_we1,
  input  dmem_idx_t  i_idx1,
  input  byte_mask_t i_mask1,
  input  xdata_t     i_wdata1,
  output logic       o_gnt0,
  output logic       o_gnt1,
  output logic       o_we,
  output dmem_idx_t  o_idx,
  output byte_mask_t o_mask,
  output xdata_t     o_wdata
);

  logic r_last_win;  // Pipe that won the last contest
  logic w_contest;

  assign w_contest = i_req0 & i_req1;

  assign o_gnt0 = i_req0 & (~i_req1 | r_last_win);
  assign o_gnt1 = i_req1 & (~i_req0 | ~r_last_win);

  // Winner's request goes to the memory
  assign o_we    = (o_gnt0 & i_we0) | (o_gnt1 & i_we1);
  assign o_idx   = o_gnt1 ? i_idx1   : i_idx0;
  assign o_mask  = o_gnt1 ? i_mask1  : i_mask0;
  assign o_wdata = o_gnt1 ? i_wdata1 : i_wdata0;

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_last_win <= 1'b1;  // Pipe 0 takes the first contest
    end else if (w_contest) begin
      r_last_win <= ~r_last_win;
    end
  end

endmodule

// ==== hdl/lsu_cfg_pkg.sv ====
package lsu_cfg_pkg;

  // ------------------------------------------------------------
  // Datapath and memory geometry
  // ------------------------------------------------------------
  localparam int XLEN_W     = 64;
  localparam int ADDR_W     = 16;
  localparam int DMEM_WORDS = 256;
  localparam int DMEM_IDX_W = 8;   // log2 of DMEM_WORDS
  localparam int TAG_W      = 6;
  localparam int BYTE_LANES = 8;

  // ------------------------------------------------------------
  // Vector types
  // ------------------------------------------------------------
  typedef logic [XLEN_W-1:0]     xdata_t;
  typedef logic [ADDR_W-1:0]     addr_t;
  typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;
  typedef logic [BYTE_LANES-1:0] byte_mask_t;  // One bit per byte
  typedef logic [TAG_W-1:0]      rd_tag_t;

endpackage

// ==== hdl/lsu_load_align.sv ====
module lsu_load_align
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
(
  input  xdata_t     i_rdata,
  input  logic [2:0] i_offset,
  input  size_e      i_size,
  input  sign_e      i_sign,
  output xdata_t     o_data
);

  xdata_t w_shifted;
  logic   w_ext;

  assign w_shifted = i_rdata >> {i_offset, 3'b000};

  always_comb begin
    w_ext = 1'b0;
    case (i_size)
      SIZE_B: begin
        w_ext  = (i_sign == SIGN_S) & w_shifted[7];
        o_data = {{(XLEN_W-8){w_ext}}, w_shifted[7:0]};
      end
      SIZE_H: begin
        w_ext  = (i_sign == SIGN_S) & w_shifted[15];
        o_data = {{(XLEN_W-16){w_ext}}, w_shifted[15:0]};
      end
      SIZE_W: begin
        w_ext  = (i_sign == SIGN_S) & w_shifted[31];
        o_data = {{(XLEN_W-32){w_ext}}, w_shifted[31:0]};
      end
      default: begin
        o_data = w_shifted;  // Full doubleword
      end
    endcase
  end

endmodule

// ==== hdl/lsu_op_pkg.sv ====
package lsu_op_pkg;

  // Immediate and operation id widths
  localparam int IMM_W   = 12;
  localparam int OP_ID_W = 4;

  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } size_e;

  typedef enum logic {
    SIGN_S = 1'b0,
    SIGN_U = 1'b1
  } sign_e;

  // Hazard returned with each completion
  typedef enum logic [1:0] {
    HAZ_NONE     = 2'd0,
    HAZ_MISALIGN = 2'd1,
    HAZ_CONFLICT = 2'd2   // Lost the memory port, replay
  } hazard_e;

endpackage

// ==== hdl/lsu_pipe.sv ====
module lsu_pipe
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_issue_valid,
  input  logic               i_issue_is_store,
  input  size_e              i_issue_size,
  input  sign_e              i_issue_sign,
  input  xdata_t             i_issue_base,
  input  logic [IMM_W-1:0]   i_issue_imm,
  input  xdata_t             i_issue_st_data,
  input  rd_tag_t            i_issue_rd,
  input  logic [OP_ID_W-1:0] i_issue_id,
  input  logic               i_mem_gnt,
  input  xdata_t             i_mem_rdata,
  output logic               o_mem_req,
  output logic               o_mem_we,
  output dmem_idx_t          o_mem_idx,
  output byte_mask_t         o_mem_mask,
  output xdata_t             o_mem_wdata,
  output logic               o_done,
  output logic [OP_ID_W-1:0] o_done_id,
  output hazard_e            o_done_hazard,
  output logic               o_wb_valid,
  output rd_tag_t            o_wb_rd,
  output xdata_t             o_wb_data
);

  // ------------------------------------------------------------
  // Stage registers
  // ------------------------------------------------------------
  logic               r_ex0_valid, r_ex1_valid, r_ex2_valid, r_ex3_wb_valid;
  logic               r_ex0_is_store, r_ex1_is_store, r_ex2_is_store;
  size_e              r_ex0_size, r_ex1_size, r_ex2_size;
  sign_e              r_ex0_sign, r_ex1_sign, r_ex2_sign;
  xdata_t             r_ex0_base, r_ex1_base;
  logic [IMM_W-1:0]   r_ex0_imm;
  addr_t              r_ex1_imm;
  xdata_t             r_ex0_st_data, r_ex1_st_data;
  rd_tag_t            r_ex0_rd, r_ex1_rd, r_ex2_rd, r_ex3_rd;
  logic [OP_ID_W-1:0] r_ex0_id, r_ex1_id, r_ex2_id;
  logic [2:0]         r_ex2_offset;
  hazard_e            r_ex2_hazard;
  xdata_t             r_ex3_data;

  addr_t      w_ex0_imm_ext;
  addr_t      w_ex1_addr;
  logic [2:0] w_ex1_offset;
  logic       w_ex1_misalign;
  byte_mask_t w_ex1_mask;
  hazard_e    w_ex1_hazard;
  xdata_t     w_ex2_ld_data;

  assign w_ex0_imm_ext = {{(ADDR_W-IMM_W){r_ex0_imm[IMM_W-1]}}, r_ex0_imm};

  // ------------------------------------------------------------
  // EX1 address, alignment and memory request
  // ------------------------------------------------------------
  assign w_ex1_addr   = r_ex1_base[ADDR_W-1:0] + r_ex1_imm;
  assign w_ex1_offset = w_ex1_addr[2:0];

  always_comb begin
    case (r_ex1_size)
      SIZE_B: begin
        w_ex1_misalign = 1'b0;
        w_ex1_mask     = byte_mask_t'(8'h01) << w_ex1_offset;
      end
      SIZE_H: begin
        w_ex1_misalign = w_ex1_offset[0];
        w_ex1_mask     = byte_mask_t'(8'h03) << w_ex1_offset;
      end
      SIZE_W: begin
        w_ex1_misalign = |w_ex1_offset[1:0];
        w_ex1_mask     = byte_mask_t'(8'h0f) << w_ex1_offset;
      end
      default: begin
        w_ex1_misalign = |w_ex1_offset;
        w_ex1_mask     = '1;
      end
    endcase
  end

  assign o_mem_req   = r_ex1_valid & ~w_ex1_misalign;
  assign o_mem_we    = r_ex1_is_store;
  assign o_mem_idx   = w_ex1_addr[DMEM_IDX_W+2:3];
  assign o_mem_mask  = w_ex1_mask;
  assign o_mem_wdata = r_ex1_st_data << {w_ex1_offset, 3'b000};  // Into the lanes

  assign w_ex1_hazard = w_ex1_misalign ? HAZ_MISALIGN :
                        ~i_mem_gnt     ? HAZ_CONFLICT : HAZ_NONE;

  // Control state
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_valid    <= 1'b0;
      r_ex1_valid    <= 1'b0;
      r_ex2_valid    <= 1'b0;
      r_ex2_hazard   <= HAZ_NONE;
      r_ex3_wb_valid <= 1'b0;
    end else begin
      r_ex0_valid    <= i_issue_valid;
      r_ex1_valid    <= r_ex0_valid;
      r_ex2_valid    <= r_ex1_valid;
      r_ex2_hazard   <= w_ex1_hazard;
      r_ex3_wb_valid <= r_ex2_valid & ~r_ex2_is_store &
                        (r_ex2_hazard == HAZ_NONE) & (r_ex2_rd != '0);
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    r_ex0_is_store <= i_issue_is_store;
    r_ex0_size     <= i_issue_size;
    r_ex0_sign     <= i_issue_sign;
    r_ex0_base     <= i_issue_base;
    r_ex0_imm      <= i_issue_imm;
    r_ex0_st_data  <= i_issue_st_data;
    r_ex0_rd       <= i_issue_rd;
    r_ex0_id       <= i_issue_id;

    r_ex1_is_store <= r_ex0_is_store;
    r_ex1_size     <= r_ex0_size;
    r_ex1_sign     <= r_ex0_sign;
    r_ex1_base     <= r_ex0_base;
    r_ex1_imm      <= w_ex0_imm_ext;
    r_ex1_st_data  <= r_ex0_st_data;
    r_ex1_rd       <= r_ex0_rd;
    r_ex1_id       <= r_ex0_id;

    r_ex2_is_store <= r_ex1_is_store;
    r_ex2_size     <= r_ex1_size;
    r_ex2_sign     <= r_ex1_sign;
    r_ex2_offset   <= w_ex1_offset;
    r_ex2_rd       <= r_ex1_rd;
    r_ex2_id       <= r_ex1_id;

    r_ex3_rd       <= r_ex2_rd;
    r_ex3_data     <= w_ex2_ld_data;
  end

  // ------------------------------------------------------------
  // EX2 completion, EX3 writeback
  // ------------------------------------------------------------
  lsu_load_align u_load_align (
    .i_rdata  (i_mem_rdata),
    .i_offset (r_ex2_offset),
    .i_size   (r_ex2_size),
    .i_sign   (r_ex2_sign),
    .o_data   (w_ex2_ld_data)
  );

  assign o_done        = r_ex2_valid;
  assign o_done_id     = r_ex2_id;
  assign o_done_hazard = r_ex2_hazard;

  assign o_wb_valid = r_ex3_wb_valid;
  assign o_wb_rd    = r_ex3_rd;
  assign o_wb_data  = r_ex3_data;

endmodule

// ==== hdl/lsu_top.sv ====
module lsu_top
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
(
  input  logic               i_clk,
  input  logic               i_reset_n,
  // Pipe 0 issue
  input  logic               i_issue_valid_0,
  input  logic               i_issue_is_store_0,
  input  size_e              i_issue_size_0,
  input  sign_e              i_issue_sign_0,
  input  xdata_t             i_issue_base_0,
  input  logic [IMM_W-1:0]   i_issue_imm_0,
  input  xdata_t             i_issue_st_data_0,
  input  rd_tag_t            i_issue_rd_0,
  input  logic [OP_ID_W-1:0] i_issue_id_0,
  // Pipe 1 issue
  input  logic               i_issue_valid_1,
  input  logic               i_issue_is_store_1,
  input  size_e              i_issue_size_1,
  input  sign_e              i_issue_sign_1,
  input  xdata_t             i_issue_base_1,
  input  logic [IMM_W-1:0]   i_issue_imm_1,
  input  xdata_t             i_issue_st_data_1,
  input  rd_tag_t            i_issue_rd_1,
  input  logic [OP_ID_W-1:0] i_issue_id_1,
  // Completion and writeback
  output logic               o_done_0,
  output logic [OP_ID_W-1:0] o_done_id_0,
  output hazard_e            o_done_hazard_0,
  output logic               o_wb_valid_0,
  output rd_tag_t            o_wb_rd_0,
  output xdata_t             o_wb_data_0,
  output logic               o_done_1,
  output logic [OP_ID_W-1:0] o_done_id_1,
  output hazard_e            o_done_hazard_1,
  output logic               o_wb_valid_1,
  output rd_tag_t            o_wb_rd_1,
  output xdata_t             o_wb_data_1
);

  logic       w_req0, w_req1;
  logic       w_we0, w_we1;
  dmem_idx_t  w_idx0, w_idx1;
  byte_mask_t w_mask0, w_mask1;
  xdata_t     w_wdata0, w_wdata1;
  logic       w_gnt0, w_gnt1;
  logic       w_we;
  dmem_idx_t  w_idx;
  byte_mask_t w_mask;
  xdata_t     w_wdata;
  xdata_t     w_rdata;  // Shared by both pipes

  lsu_pipe u_pipe0 (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid_0),
    .i_issue_is_store (i_issue_is_store_0),
    .i_issue_size     (i_issue_size_0),
    .i_issue_sign     (i_issue_sign_0),
    .i_issue_base     (i_issue_base_0),
    .i_issue_imm      (i_issue_imm_0),
    .i_issue_st_data  (i_issue_st_data_0),
    .i_issue_rd       (i_issue_rd_0),
    .i_issue_id       (i_issue_id_0),
    .i_mem_gnt        (w_gnt0),
    .i_mem_rdata      (w_rdata),
    .o_mem_req        (w_req0),
    .o_mem_we         (w_we0),
    .o_mem_idx        (w_idx0),
    .o_mem_mask       (w_mask0),
    .o_mem_wdata      (w_wdata0),
    .o_done           (o_done_0),
    .o_done_id        (o_done_id_0),
    .o_done_hazard    (o_done_hazard_0),
    .o_wb_valid       (o_wb_valid_0),
    .o_wb_rd          (o_wb_rd_0),
    .o_wb_data        (o_wb_data_0)
  );

  lsu_pipe u_pipe1 (
    .i_clk            (i_clk),
    .i_reset_n        (i_reset_n),
    .i_issue_valid    (i_issue_valid_1),
    .i_issue_is_store (i_issue_is_store_1),
    .i_issue_size     (i_issue_size_1),
    .i_issue_sign     (i_issue_sign_1),
    .i_issue_base     (i_issue_base_1),
    .i_issue_imm      (i_issue_imm_1),
    .i_issue_st_data  (i_issue_st_data_1),
    .i_issue_rd       (i_issue_rd_1),
    .i_issue_id       (i_issue_id_1),
    .i_mem_gnt        (w_gnt1),
    .i_mem_rdata      (w_rdata),
    .o_mem_req        (w_req1),
    .o_mem_we         (w_we1),
    .o_mem_idx        (w_idx1),
    .o_mem_mask       (w_mask1),
    .o_mem_wdata      (w_wdata1),
    .o_done           (o_done_1),
    .o_done_id        (o_done_id_1),
    .o_done_hazard    (o_done_hazard_1),
    .o_wb_valid       (o_wb_valid_1),
    .o_wb_rd          (o_wb_rd_1),
    .o_wb_data        (o_wb_data_1)
  );

  dmem_arbiter u_arbiter (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_req0    (w_req0),
    .i_we0     (w_we0),
    .i_idx0    (w_idx0),
    .i_mask0   (w_mask0),
    .i_wdata0  (w_wdata0),
    .i_req1    (w_req1),
    .i_we1     (w_we1),
    .i_idx1    (w_idx1),
    .i_mask1   (w_mask1),
    .i_wdata1  (w_wdata1),
    .o_gnt0    (w_gnt0),
    .o_gnt1    (w_gnt1),
    .o_we      (w_we),
    .o_idx     (w_idx),
    .o_mask    (w_mask),
    .o_wdata   (w_wdata)
  );

  dmem u_dmem (
    .i_clk   (i_clk),
    .i_en    (w_gnt0 | w_gnt1),  // Any granted request
    .i_we    (w_we),
    .i_idx   (w_idx),
    .i_mask  (w_mask),
    .i_wdata (w_wdata),
    .o_rdata (w_rdata)
  );

endmodule

// ==== tests/lsu_trace.txt ====
# cycle name, then per pipe 0 and pipe 1: valid store size sign base imm st_data rd id hazard wb_data
# size 0 byte 1 half 2 word 3 dword, sign 1 unsigned, hazard 0 none 1 misaligned 2 conflict
0 sd_fill        1 1 3 0 100 008 c53412fe80007f81 00 0 0 0   0 0 0 0 0 0 0 0 0 0 0
1 ld_dword       0 0 0 0 0 0 0 0 0 0 0   1 0 3 0 110 ff8 0 05 1 0 c53412fe80007f81
2 lb_off0        1 0 0 0 108 000 0 06 2 0 ffffffffffffff81   0 0 0 0 0 0 0 0 0 0 0
3 lbu_off3       0 0 0 0 0 0 0 0 0 0 0   1 0 0 1 100 00b 0 07 3 0 0000000000000080
4 lh_off2        1 0 1 0 10a 000 0 08 4 0 ffffffffffff8000   0 0 0 0 0 0 0 0 0 0 0
5 lhu_off6       0 0 0 0 0 0 0 0 0 0 0   1 0 1 1 108 006 0 09 5 0 000000000000c534
6 lw_off0        1 0 2 0 108 000 0 0a 6 0 ffffffff80007f81   0 0 0 0 0 0 0 0 0 0 0
7 lwu_off4       0 0 0 0 0 0 0 0 0 0 0   1 0 2 1 104 008 0 0b 7 0 00000000c53412fe
8 lw_off4        1 0 2 0 10c 000 0 0c 8 0 ffffffffc53412fe   0 0 0 0 0 0 0 0 0 0 0
9 lb_off5        0 0 0 0 0 0 0 0 0 0 0   1 0 0 0 10d 000 0 0d 9 0 0000000000000012
10 sb_off6       1 1 0 0 100 00e 55aa 00 a 0 0   0 0 0 0 0 0 0 0 0 0 0
11 sh_off2       0 0 0 0 0 0 0 0 0 0 0   1 1 1 0 10a 000 7777beef 00 b 0 0
12 ld_narrow     1 0 3 0 108 000 0 0e c 0 c5aa12febeef7f81   0 0 0 0 0 0 0 0 0 0 0
13 sw_off4       0 0 0 0 0 0 0 0 0 0 0   1 1 2 0 108 004 a5a5a5a513579bdf 00 d 0 0
14 ld_after_sw   1 0 3 0 108 000 0 0f e 0 13579bdfbeef7f81   0 0 0 0 0 0 0 0 0 0 0
15 lh_misalign   0 0 0 0 0 0 0 0 0 0 0   1 0 1 0 109 000 0 10 f 1 0
16 sd_misalign   1 1 3 0 108 004 deaddeaddeaddead 00 0 1 0   0 0 0 0 0 0 0 0 0 0 0
17 lw_misalign   0 0 0 0 0 0 0 0 0 0 0   1 0 2 0 108 002 0 10 1 1 0
18 ld_unchanged  1 0 3 0 108 000 0 11 2 0 13579bdfbeef7f81   0 0 0 0 0 0 0 0 0 0 0
19 sd_contest    1 1 3 0 118 000 0123456789abcdef 00 3 0 0   1 1 3 0 120 000 fedcba9876543210 00 4 2 0
20 sd_replay     0 0 0 0 0 0 0 0 0 0 0   1 1 3 0 110 010 fedcba9876543210 00 4 0 0
21 ld_contest    1 0 3 0 120 000 0 12 5 2 0   1 0 3 0 118 000 0 13 6 0 0123456789abcdef
22 ld_replay     1 0 3 0 128 ff8 0 12 5 0 fedcba9876543210   0 0 0 0 0 0 0 0 0 0 0
23 lw_contest    1 0 2 0 118 000 0 14 7 0 ffffffff89abcdef   1 0 0 1 118 007 0 15 8 2 0
24 lb_replay     1 0 1 0 121 000 0 16 9 1 0   1 0 0 1 118 007 0 15 8 0 0000000000000001
25 ld_contest2   1 0 3 0 118 000 0 17 a 2 0   1 0 3 0 120 000 0 18 b 0 fedcba9876543210
26 ld_replay2    1 0 3 0 118 000 0 17 a 0 0123456789abcdef   0 0 0 0 0 0 0 0 0 0 0
27 ld_rd_zero    0 0 0 0 0 0 0 0 0 0 0   1 0 3 0 108 000 0 00 c 0 0

// ==== tests/tb_lsu.sv ====
module tb_lsu
  import lsu_cfg_pkg::*;
  import lsu_op_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYC = 64;

  logic               i_clk;
  logic               i_reset_n;
  logic               i_issue_valid_0, i_issue_valid_1;
  logic               i_issue_is_store_0, i_issue_is_store_1;
  size_e              i_issue_size_0, i_issue_size_1;
  sign_e              i_issue_sign_0, i_issue_sign_1;
  xdata_t             i_issue_base_0, i_issue_base_1;
  logic [IMM_W-1:0]   i_issue_imm_0, i_issue_imm_1;
  xdata_t             i_issue_st_data_0, i_issue_st_data_1;
  rd_tag_t            i_issue_rd_0, i_issue_rd_1;
  logic [OP_ID_W-1:0] i_issue_id_0, i_issue_id_1;
  logic               o_done_0, o_done_1;
  logic [OP_ID_W-1:0] o_done_id_0, o_done_id_1;
  hazard_e            o_done_hazard_0, o_done_hazard_1;
  logic               o_wb_valid_0, o_wb_valid_1;
  rd_tag_t            o_wb_rd_0, o_wb_rd_1;
  xdata_t             o_wb_data_0, o_wb_data_1;

  // ------------------------------------------------------------
  // Trace contents, indexed by issue cycle and pipe
  // ------------------------------------------------------------
  logic               tr_present [MAX_CYC];
  string              tr_name    [MAX_CYC];
  int                 tr_errors  [MAX_CYC];
  logic               tr_valid   [MAX_CYC][2];
  logic               tr_store   [MAX_CYC][2];
  logic [1:0]         tr_size    [MAX_CYC][2];
  logic               tr_sign    [MAX_CYC][2];
  xdata_t             tr_base    [MAX_CYC][2];
  logic [IMM_W-1:0]   tr_imm     [MAX_CYC][2];
  xdata_t             tr_st_data [MAX_CYC][2];
  rd_tag_t            tr_rd      [MAX_CYC][2];
  logic [OP_ID_W-1:0] tr_id      [MAX_CYC][2];
  logic [1:0]         tr_hazard  [MAX_CYC][2];
  xdata_t             tr_wb_data [MAX_CYC][2];

  int   last_cyc;
  int   errors;
  int   n_tests;
  int   n_failed;
  logic trace_loaded = 1'b0;

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  lsu_top i_dut (.*);

  task automatic load_trace();
    int               fd;
    int               cyc;
    int               n;
    logic             at_end;
    logic             ok;
    string            tok;
    string            name;
    logic [63:0]      val;
    logic [8*128-1:0] line_buf;
    for (int c = 0; c < MAX_CYC; c++) begin
      tr_present[c] = 1'b0;
      tr_errors[c]  = 0;
      for (int p = 0; p < 2; p++) begin
        tr_valid[c][p]   = 1'b0;
        tr_store[c][p]   = 1'b0;
        tr_size[c][p]    = 2'd0;
        tr_sign[c][p]    = 1'b0;
        tr_base[c][p]    = '0;
        tr_imm[c][p]     = '0;
        tr_st_data[c][p] = '0;
        tr_rd[c][p]      = '0;
        tr_id[c][p]      = '0;
        tr_hazard[c][p]  = 2'd0;
        tr_wb_data[c][p] = '0;
      end
    end
    last_cyc = 0;
    at_end   = 1'b0;
    fd = $fopen("tests/lsu_trace.txt", "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the trace file tests/lsu_trace.txt");
      errors++;
      at_end = 1'b1;
    end
    while (!at_end) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        at_end = 1'b1;
      end else if (tok[0] == "#") begin
        n = $fgets(line_buf, fd);  // Rest of a comment line
      end else begin
        cyc = tok.atoi();
        n   = $fscanf(fd, "%s", name);
        ok  = (cyc >= 0) && (cyc < MAX_CYC - 5);
        if (!ok) begin
          $display("ERROR: trace cycle %0d out of range, line %s skipped", cyc, name);
          errors++;
        end
        for (int p = 0; p < 2; p++) begin
          for (int k = 0; k < 11; k++) begin
            n = $fscanf(fd, "%h", val);
            if (ok) begin
              case (k)
                0:       tr_valid[cyc][p]   = val[0];
                1:       tr_store[cyc][p]   = val[0];
                2:       tr_size[cyc][p]    = val[1:0];
                3:       tr_sign[cyc][p]    = val[0];
                4:       tr_base[cyc][p]    = val;
                5:       tr_imm[cyc][p]     = val[IMM_W-1:0];
                6:       tr_st_data[cyc][p] = val;
                7:       tr_rd[cyc][p]      = val[TAG_W-1:0];
                8:       tr_id[cyc][p]      = val[OP_ID_W-1:0];
                9:       tr_hazard[cyc][p]  = val[1:0];
                default: tr_wb_data[cyc][p] = val;
              endcase
            end
          end
        end
        if (ok) begin
          tr_present[cyc] = 1'b1;
          tr_name[cyc]    = name;
          if (cyc > last_cyc) last_cyc = cyc;
        end
      end
    end
    if (fd != 0) $fclose(fd);
  endtask

  // Both pipes, applied after the rising edge
  task automatic drive_cycle(input int c);
    i_issue_valid_0    <= tr_valid[c][0];
    i_issue_is_store_0 <= tr_store[c][0];
    i_issue_size_0     <= size_e'(tr_size[c][0]);
    i_issue_sign_0     <= sign_e'(tr_sign[c][0]);
    i_issue_base_0     <= tr_base[c][0];
    i_issue_imm_0      <= tr_imm[c][0];
    i_issue_st_data_0  <= tr_st_data[c][0];
    i_issue_rd_0       <= tr_rd[c][0];
    i_issue_id_0       <= tr_id[c][0];
    i_issue_valid_1    <= tr_valid[c][1];
    i_issue_is_store_1 <= tr_store[c][1];
    i_issue_size_1     <= size_e'(tr_size[c][1]);
    i_issue_sign_1     <= sign_e'(tr_sign[c][1]);
    i_issue_base_1     <= tr_base[c][1];
    i_issue_imm_1      <= tr_imm[c][1];
    i_issue_st_data_1  <= tr_st_data[c][1];
    i_issue_rd_1       <= tr_rd[c][1];
    i_issue_id_1       <= tr_id[c][1];
  endtask

  // ------------------------------------------------------------
  // Expected behavior and checks
  // ------------------------------------------------------------
  function automatic string test_name(input int c);
    if (c >= 0 && tr_present[c]) return tr_name[c];
    return "idle";
  endfunction

  function automatic logic expect_done(input int c, input int p);
    return c >= 0 && tr_valid[c][p];
  endfunction

  // Loads only, no hazard, rd 0 never written
  function automatic logic expect_wb(input int c, input int p);
    return c >= 0 && tr_valid[c][p] && !tr_store[c][p] &&
           tr_hazard[c][p] == 2'd0 && tr_rd[c][p] != '0;
  endfunction

  task automatic record_error(input int c);
    errors++;
    if (c >= 0 && tr_present[c]) tr_errors[c]++;
  endtask

  task automatic check_done(input int c, input int p, input logic done,
                            input logic [OP_ID_W-1:0] id, input hazard_e hazard);
    logic exp;
    exp = expect_done(c, p);
    if (done !== exp) begin
      $display("MISMATCH %s pipe%0d done: expected %0b actual %0b",
               test_name(c), p, exp, done);
      record_error(c);
    end else if (exp && id !== tr_id[c][p]) begin
      $display("MISMATCH %s pipe%0d done id: expected %0h actual %0h",
               test_name(c), p, tr_id[c][p], id);
      record_error(c);
    end else if (exp && hazard !== tr_hazard[c][p]) begin
      $display("MISMATCH %s pipe%0d hazard: expected %0d actual %0d",
               test_name(c), p, tr_hazard[c][p], hazard);
      record_error(c);
    end
  endtask

  task automatic check_wb(input int c, input int p, input logic valid,
                          input rd_tag_t rd, input xdata_t data);
    logic exp;
    exp = expect_wb(c, p);
    if (valid !== exp) begin
      $display("MISMATCH %s pipe%0d writeback valid: expected %0b actual %0b",
               test_name(c), p, exp, valid);
      record_error(c);
    end else if (exp && rd !== tr_rd[c][p]) begin
      $display("MISMATCH %s pipe%0d writeback rd: expected %0h actual %0h",
               test_name(c), p, tr_rd[c][p], rd);
      record_error(c);
    end else if (exp && data !== tr_wb_data[c][p]) begin
      $display("MISMATCH %s pipe%0d writeback data: expected %h actual %h",
               test_name(c), p, tr_wb_data[c][p], data);
      record_error(c);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    n_tests++;
    if (errs == 0) begin
      $display("test %-14s ok", name);
    end else begin
      n_failed++;
      $display("test %-14s failed with %0d errors", name, errs);
    end
  endtask

  // Completion of cycle c-3 and writeback of cycle c-4
  task automatic check_cycle(input int c);
    check_done(c - 3, 0, o_done_0, o_done_id_0, o_done_hazard_0);
    check_done(c - 3, 1, o_done_1, o_done_id_1, o_done_hazard_1);
    check_wb(c - 4, 0, o_wb_valid_0, o_wb_rd_0, o_wb_data_0);
    check_wb(c - 4, 1, o_wb_valid_1, o_wb_rd_1, o_wb_data_1);
    if (c >= 4 && tr_present[c - 4]) begin
      report_test(tr_name[c - 4], tr_errors[c - 4]);
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    int reset_errs;
    errors    = 0;
    n_tests   = 0;
    n_failed  = 0;
    i_reset_n = 1'b0;
    load_trace();
    drive_cycle(MAX_CYC - 1);  // Slot never used by the trace
    trace_loaded = 1'b1;
    reset_errs   = errors;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    check_cycle(-10);
    @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_cycle(-10);  // Quiet right after release
    report_test("reset_idle", errors - reset_errs);
    for (int c = 0; c <= last_cyc + 4; c++) begin
      @(posedge i_clk);
      drive_cycle(c);
      @(negedge i_clk);
      check_cycle(c);
    end
    $display("tests run %0d, failed %0d, errors %0d", n_tests, n_failed, errors);
    if (errors == 0 && n_failed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (trace_loaded);
    #((last_cyc + 20) * 100);
    $display("ERROR: watchdog expired before the trace finished");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== verilog.f ====
hdl/lsu_cfg_pkg.sv
hdl/lsu_op_pkg.sv
hdl/lsu_load_align.sv
hdl/dmem_arbiter.sv
hdl/dmem.sv
hdl/lsu_pipe.sv
hdl/lsu_top.sv
tests/tb_lsu.sv
